// ==== Bender.yml ====
package:
  name: retire_core

sources:
  - logic/retire_pkg.sv
  - logic/alu_unit.sv
  - logic/branch_unit.sv
  - logic/reorder_buffer.sv
  - logic/retire_core.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/retire_core_tb.sv

// ==== logic/alu_unit.sv ====
// single-stage integer unit with signed add/sub overflow detection
`timescale 1ns/1ns

module alu_unit import retire_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 issue_valid,
  input  logic [rob_tag_w-1:0] issue_robid,
  input  op_e                  op,
  input  logic                 dispatch_error,
  input  logic [data_w-1:0]    src_a,
  input  logic [data_w-1:0]    src_b,
  output logic                 wb_valid,
  output logic [rob_tag_w-1:0] wb_robid,
  output logic [data_w-1:0]    wb_result,
  output logic                 wb_error,
  output cause_e               wb_cause
);

  logic              take;
  logic [data_w-1:0] result;
  logic              ovf;

  // errored dispatches never execute
  assign take = issue_valid & is_alu_op(op) & ~dispatch_error;

  always_comb begin
    result = '0;
    ovf    = 1'b0;
    case (op)
      op_add: begin
        result = src_a + src_b;
        // same operand signs, different result sign
        ovf = (src_a[data_w-1] == src_b[data_w-1]) && (result[data_w-1] != src_a[data_w-1]);
      end
      op_sub: begin
        result = src_a - src_b;
        ovf = (src_a[data_w-1] != src_b[data_w-1]) && (result[data_w-1] != src_a[data_w-1]);
      end
      op_xor:  result = src_a ^ src_b;
      op_and:  result = src_a & src_b;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      // an issue in the flush cycle is younger than the flushing entry
      wb_valid <= take & ~flush;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      wb_robid  <= issue_robid;
      wb_result <= result;
      wb_error  <= ovf;
      wb_cause  <= ovf ? cause_overflow : cause_none;
    end
  end

  a_no_wb_after_flush: assert property (
    @(posedge clk) disable iff (!rst_n) flush |=> !wb_valid
  );

endmodule

// ==== logic/branch_unit.sv ====
// two-stage branch resolver, eq/ne/signed lt compare and jump
`timescale 1ns/1ns

module branch_unit import retire_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 issue_valid,
  input  logic [rob_tag_w-1:0] issue_robid,
  input  op_e                  op,
  input  logic                 dispatch_error,
  input  logic [data_w-1:0]    src_a,
  input  logic [data_w-1:0]    src_b,
  output logic                 wb_valid,
  output logic [rob_tag_w-1:0] wb_robid,
  output logic                 wb_taken
);

  logic                 take;
  logic                 s1_valid;
  logic [rob_tag_w-1:0] s1_robid;
  op_e                  s1_op;
  logic [data_w-1:0]    s1_a;
  logic [data_w-1:0]    s1_b;
  logic                 cond;

  assign take = issue_valid & is_branch_op(op) & ~dispatch_error;

  // stage two condition, from the stage one operands
  always_comb begin
    case (s1_op)
      op_beq:  cond = (s1_a == s1_b);
      op_bne:  cond = (s1_a != s1_b);
      op_blt:  cond = ($signed(s1_a) < $signed(s1_b));
      op_jump: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // both stages are squashed together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      s1_valid <= take & ~flush;
      wb_valid <= s1_valid & ~flush;
    end
  end

  // stage one: operands and tag
  always_ff @(posedge clk) begin
    if (take) begin
      s1_robid <= issue_robid;
      s1_op    <= op;
      s1_a     <= src_a;
      s1_b     <= src_b;
    end
  end

  // stage two: resolved outcome
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      wb_robid <= s1_robid;
      wb_taken <= cond;
    end
  end

endmodule

// ==== logic/reorder_buffer.sv ====
// reorder buffer: tag allocation, dual write-back, in-order retire, flush and exceptions
`timescale 1ns/1ns

module reorder_buffer import retire_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // dispatch
  input  logic                 dispatch_valid,
  input  op_e                  op,
  input  logic [addr_w-1:0]    addr,
  input  logic                 dst_en,
  input  logic [reg_w-1:0]     rd,
  input  logic                 bp_taken,
  input  logic [addr_w-1:0]    target,
  input  logic                 dispatch_error,
  input  cause_e               dispatch_cause,
  input  logic [addr_w-1:0]    csr_tvec,
  // write-back from the integer unit
  input  logic                 alu_wb_valid,
  input  logic [rob_tag_w-1:0] alu_wb_robid,
  input  logic [data_w-1:0]    alu_wb_result,
  input  logic                 alu_wb_error,
  input  cause_e               alu_wb_cause,
  // write-back from the branch unit
  input  logic                 br_wb_valid,
  input  logic [rob_tag_w-1:0] br_wb_robid,
  input  logic                 br_wb_taken,
  output logic                 full,
  output logic [rob_tag_w-1:0] robid,
  output logic                 issue_valid,
  output logic [rob_tag_w-1:0] issue_robid,
  // retirement
  output logic                 ret_valid,
  output logic [reg_w-1:0]     ret_rd,
  output logic [data_w-1:0]    ret_result,
  output logic                 ret_store,
  output logic                 ret_branch,
  output logic                 ret_bp_taken,
  output logic                 flush,
  output logic [addr_w-1:0]    flush_pc,
  output logic                 csr_valid,
  output logic [addr_w-1:0]    csr_epc,
  output cause_e               csr_cause
);

  // entry storage
  logic [rob_depth-1:0] ent_complete;
  logic [rob_depth-1:0] ent_error;
  logic [rob_depth-1:0] ent_dst_en;
  logic [rob_depth-1:0] ent_bp_taken;
  logic [rob_depth-1:0] ent_taken;
  op_e                  ent_op     [rob_depth];
  logic [addr_w-1:0]    ent_addr   [rob_depth];
  logic [reg_w-1:0]     ent_rd     [rob_depth];
  logic [addr_w-1:0]    ent_target [rob_depth];
  logic [data_w-1:0]    ent_result [rob_depth];
  cause_e               ent_cause  [rob_depth];

  // pointers with polarity bit on top
  logic [rob_tag_w-1:0] head_ptr;
  logic [rob_tag_w-1:0] tail_ptr;
  logic [rob_tag_w-1:0] head_next;
  logic [rob_tag_w-1:0] rd_ptr;
  logic [rob_idx_w-1:0] rd_idx;
  logic [rob_idx_w-1:0] tail_idx;
  logic [rob_idx_w-1:0] alu_idx;
  logic [rob_idx_w-1:0] br_idx;
  logic                 empty;
  logic                 accept;
  logic                 rd_avail;

  // retire register
  logic                 rr_valid;
  op_e                  rr_op;
  logic [addr_w-1:0]    rr_addr;
  logic                 rr_dst_en;
  logic [reg_w-1:0]     rr_rd;
  logic                 rr_bp_taken;
  logic [addr_w-1:0]    rr_target;
  logic [data_w-1:0]    rr_result;
  cause_e               rr_cause;
  logic                 rr_error;
  logic                 rr_taken;
  logic                 rr_is_branch;
  logic                 br_taken;
  logic                 mispredict;

  // window distances, for the tag check
  logic [rob_tag_w-1:0] occupancy;
  logic [rob_tag_w-1:0] alu_dist;
  logic [rob_tag_w-1:0] br_dist;

  assign tail_idx = tail_ptr[rob_idx_w-1:0];
  assign alu_idx  = alu_wb_robid[rob_idx_w-1:0];
  assign br_idx   = br_wb_robid[rob_idx_w-1:0];

  assign empty  = (head_ptr == tail_ptr);
  assign full   = (head_ptr[rob_idx_w-1:0] == tail_idx) &&
                  (head_ptr[rob_idx_w] != tail_ptr[rob_idx_w]);
  assign accept = dispatch_valid & ~full;

  assign robid       = tail_ptr;
  assign issue_valid = accept;
  assign issue_robid = tail_ptr;

  // head still names the entry in the retire register, so skip past it
  assign head_next = head_ptr + rob_tag_w'(1);
  assign rd_ptr    = rr_valid ? head_next : head_ptr;
  assign rd_idx    = rd_ptr[rob_idx_w-1:0];
  assign rd_avail  = (rd_ptr != tail_ptr);

  // retire decisions
  assign rr_is_branch = is_branch_op(rr_op);
  assign br_taken     = rr_is_branch & rr_taken;
  assign mispredict   = (rr_op == op_jump) | (rr_is_branch & (br_taken != rr_bp_taken));

  assign flush    = rr_valid & (rr_error | mispredict);
  assign flush_pc = rr_error ? csr_tvec : (br_taken ? rr_target : rr_addr + addr_w'(1));

  assign ret_valid    = rr_valid & rr_dst_en & ~rr_error;
  assign ret_rd       = rr_rd;
  assign ret_result   = rr_result;
  assign ret_store    = rr_valid & ~rr_error & (rr_op == op_store);
  assign ret_branch   = rr_valid & ~rr_error & rr_is_branch;
  assign ret_bp_taken = br_taken;

  assign csr_valid = rr_valid & rr_error;
  assign csr_epc   = rr_addr;
  assign csr_cause = rr_cause;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      rr_valid <= 1'b0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      rr_valid <= 1'b0;
    end else begin
      if (rr_valid) begin
        head_ptr <= head_next;
      end
      if (accept) begin
        tail_ptr <= tail_ptr + rob_tag_w'(1);
      end
      rr_valid <= rd_avail & ent_complete[rd_idx];
    end
  end

  // retire register payload
  always_ff @(posedge clk) begin
    rr_op       <= ent_op[rd_idx];
    rr_addr     <= ent_addr[rd_idx];
    rr_dst_en   <= ent_dst_en[rd_idx];
    rr_rd       <= ent_rd[rd_idx];
    rr_bp_taken <= ent_bp_taken[rd_idx];
    rr_target   <= ent_target[rd_idx];
    rr_result   <= ent_result[rd_idx];
    rr_cause    <= ent_cause[rd_idx];
    rr_error    <= ent_error[rd_idx];
    rr_taken    <= ent_taken[rd_idx];
  end

  // dispatch and write-back never hit the same entry
  always_ff @(posedge clk) begin
    if (accept) begin
      ent_op[tail_idx]       <= op;
      ent_addr[tail_idx]     <= addr;
      ent_dst_en[tail_idx]   <= dst_en;
      ent_rd[tail_idx]       <= rd;
      ent_bp_taken[tail_idx] <= bp_taken;
      ent_target[tail_idx]   <= target;
      ent_error[tail_idx]    <= dispatch_error;
      ent_cause[tail_idx]    <= dispatch_error ? dispatch_cause : cause_none;
      // stores, nops and errored entries need no unit
      ent_complete[tail_idx] <= dispatch_error | ~(is_alu_op(op) | is_branch_op(op));
    end
    if (alu_wb_valid) begin
      ent_complete[alu_idx] <= 1'b1;
      ent_error[alu_idx]    <= alu_wb_error;
      ent_cause[alu_idx]    <= alu_wb_cause;
      ent_result[alu_idx]   <= alu_wb_result;
    end
    if (br_wb_valid) begin
      ent_complete[br_idx] <= 1'b1;
      ent_taken[br_idx]    <= br_wb_taken;
    end
  end

  assign occupancy = tail_ptr - head_ptr;
  assign alu_dist  = alu_wb_robid - head_ptr;
  assign br_dist   = br_wb_robid - head_ptr;

  a_wb_in_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(alu_wb_valid && alu_dist >= occupancy) && !(br_wb_valid && br_dist >= occupancy)
  );

  // after a flush nothing retires or writes back
  a_flush_clears: assert property (
    @(posedge clk) disable iff (!rst_n)
    flush |-> rr_valid ##1 !(rr_valid || alu_wb_valid || br_wb_valid)
  );

  // occupancy stays within the depth, and an empty buffer holds nothing to retire
  a_occupancy: assert property (
    @(posedge clk) disable iff (!rst_n)
    (occupancy <= rob_tag_w'(rob_depth)) && !(empty && rr_valid)
  );

endmodule

// ==== logic/retire_core.sv ====
// top level, reorder buffer with the integer and branch units
`timescale 1ns/1ns

module retire_core import retire_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 dispatch_valid,
  input  op_e                  op,
  input  logic [addr_w-1:0]    addr,
  input  logic                 dst_en,
  input  logic [reg_w-1:0]     rd,
  input  logic [data_w-1:0]    src_a,
  input  logic [data_w-1:0]    src_b,
  input  logic                 bp_taken,
  input  logic [addr_w-1:0]    target,
  input  logic                 dispatch_error,
  input  cause_e               dispatch_cause,
  input  logic [addr_w-1:0]    csr_tvec,
  output logic                 full,
  output logic [rob_tag_w-1:0] robid,
  output logic                 ret_valid,
  output logic [reg_w-1:0]     ret_rd,
  output logic [data_w-1:0]    ret_result,
  output logic                 ret_store,
  output logic                 ret_branch,
  output logic                 ret_bp_taken,
  output logic                 flush,
  output logic [addr_w-1:0]    flush_pc,
  output logic                 csr_valid,
  output logic [addr_w-1:0]    csr_epc,
  output cause_e               csr_cause
);

  logic                 issue_valid;
  logic [rob_tag_w-1:0] issue_robid;

  logic                 alu_wb_valid;
  logic [rob_tag_w-1:0] alu_wb_robid;
  logic [data_w-1:0]    alu_wb_result;
  logic                 alu_wb_error;
  cause_e               alu_wb_cause;

  logic                 br_wb_valid;
  logic [rob_tag_w-1:0] br_wb_robid;
  logic                 br_wb_taken;

  reorder_buffer rob_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .op             (op),
    .addr           (addr),
    .dst_en         (dst_en),
    .rd             (rd),
    .bp_taken       (bp_taken),
    .target         (target),
    .dispatch_error (dispatch_error),
    .dispatch_cause (dispatch_cause),
    .csr_tvec       (csr_tvec),
    .alu_wb_valid   (alu_wb_valid),
    .alu_wb_robid   (alu_wb_robid),
    .alu_wb_result  (alu_wb_result),
    .alu_wb_error   (alu_wb_error),
    .alu_wb_cause   (alu_wb_cause),
    .br_wb_valid    (br_wb_valid),
    .br_wb_robid    (br_wb_robid),
    .br_wb_taken    (br_wb_taken),
    .full           (full),
    .robid          (robid),
    .issue_valid    (issue_valid),
    .issue_robid    (issue_robid),
    .ret_valid      (ret_valid),
    .ret_rd         (ret_rd),
    .ret_result     (ret_result),
    .ret_store      (ret_store),
    .ret_branch     (ret_branch),
    .ret_bp_taken   (ret_bp_taken),
    .flush          (flush),
    .flush_pc       (flush_pc),
    .csr_valid      (csr_valid),
    .csr_epc        (csr_epc),
    .csr_cause      (csr_cause)
  );

  // operands go straight from the top to both units
  alu_unit alu_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .issue_valid    (issue_valid),
    .issue_robid    (issue_robid),
    .op             (op),
    .dispatch_error (dispatch_error),
    .src_a          (src_a),
    .src_b          (src_b),
    .wb_valid       (alu_wb_valid),
    .wb_robid       (alu_wb_robid),
    .wb_result      (alu_wb_result),
    .wb_error       (alu_wb_error),
    .wb_cause       (alu_wb_cause)
  );

  branch_unit br_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .issue_valid    (issue_valid),
    .issue_robid    (issue_robid),
    .op             (op),
    .dispatch_error (dispatch_error),
    .src_a          (src_a),
    .src_b          (src_b),
    .wb_valid       (br_wb_valid),
    .wb_robid       (br_wb_robid),
    .wb_taken       (br_wb_taken)
  );

endmodule

// ==== logic/retire_pkg.sv ====
// buffer sizing, opcode and cause enums, and op class helpers
package retire_pkg;

  // buffer geometry
  localparam int rob_depth = 16;
  localparam int rob_idx_w = 4;
  // one extra tag bit carries the wrap polarity
  localparam int rob_tag_w = rob_idx_w + 1;

  // datapath widths
  localparam int data_w = 32;
  localparam int addr_w = 30;
  localparam int reg_w  = 5;

  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_xor   = 4'd2,
    op_and   = 4'd3,
    op_beq   = 4'd4,
    op_bne   = 4'd5,
    op_blt   = 4'd6,
    op_jump  = 4'd7,
    op_store = 4'd8,
    op_nop   = 4'd9
  } op_e;

  typedef enum logic [2:0] {
    cause_none     = 3'd0,
    cause_fetch    = 3'd1,
    cause_illegal  = 3'd2,
    cause_overflow = 3'd3
  } cause_e;

  // ops executed by the integer unit
  function automatic logic is_alu_op(op_e o);
    return o inside {op_add, op_sub, op_xor, op_and};
  endfunction

  // ops resolved by the branch unit, jump included
  function automatic logic is_branch_op(op_e o);
    return o inside {op_beq, op_bne, op_blt, op_jump};
  endfunction

endpackage

// ==== retire_core.f ====
logic/retire_pkg.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/reorder_buffer.sv
logic/retire_core.sv
testbench/tb_clock.sv
testbench/retire_core_tb.sv

// ==== testbench/retire_cases.txt ====
# op addr dst_en rd src_a src_b bp_taken target error cause expected (all hex)
# op 0 add 1 sub 2 xor 3 and 4 beq 5 bne 6 blt 7 jump 8 store 9 nop; expected is result or taken
0 100 1 01 00000005 00000007 0 000 0 0 0000000c
4 101 0 00 00000003 00000003 1 200 0 0 00000001
2 102 1 02 0000f0f0 00000ff0 0 000 0 0 0000ff00
8 103 0 00 00000000 00000000 0 000 0 0 00000000
3 104 0 03 000000ff 0000000f 0 000 0 0 0000000f
5 105 0 00 00000001 00000001 0 300 0 0 00000000
1 106 1 04 00000010 00000003 0 000 0 0 0000000d
6 107 0 00 ffffffff 00000001 0 400 0 0 00000001
0 108 1 05 00000001 00000002 0 000 0 0 00000003
9 109 0 00 00000000 00000000 0 000 0 0 00000000
0 10a 1 06 7fffffff 00000001 0 000 0 0 80000000
8 10b 0 00 00000000 00000000 0 000 0 0 00000000
7 10c 0 00 00000000 00000000 1 500 0 0 00000001
0 10d 1 07 00000020 00000022 0 000 0 0 00000042
4 10e 0 00 00000001 00000002 1 600 0 0 00000000
2 10f 1 08 aaaa5555 ffff0000 0 000 0 0 55555555
0 110 1 09 00000000 00000000 0 000 1 1 00000000
1 111 1 0a 80000000 00000001 0 000 0 0 7fffffff
3 112 1 0b 12345678 ff00ff00 0 000 0 0 12005600
8 113 0 00 00000000 00000000 0 000 1 2 00000000
5 114 0 00 00000005 00000006 1 700 0 0 00000001
0 115 1 0c 00000100 00000200 0 000 0 0 00000300
6 116 0 00 00000005 ffffffff 0 000 0 0 00000000
1 117 1 0d 00000003 00000005 0 000 0 0 fffffffe
8 118 0 00 00000000 00000000 0 000 0 0 00000000
7 119 0 00 00000000 00000000 0 800 0 0 00000001
0 11a 1 0e 00000001 00000001 0 000 0 0 00000002
2 11b 1 0f 00000001 00000003 0 000 0 0 00000002
4 11c 0 00 00000004 00000004 0 900 0 0 00000001
8 11d 0 00 00000000 00000000 0 000 0 0 00000000

// ==== testbench/retire_core_tb.sv ====
// testbench for retire_core: case file reader, dispatch driver, in-order retire model
`timescale 1ns/1ns

module retire_core_tb import retire_pkg::*; ();

  localparam int max_cases   = 64;
  localparam int burst_first = 8;
  localparam int burst_last  = 27;
  localparam logic [addr_w-1:0] trap_vec = 30'h0000_1000;

  logic clk, rst_n;
  logic dispatch_valid, dst_en, bp_taken, dispatch_error;
  op_e op;
  logic [addr_w-1:0] addr, target, csr_tvec, flush_pc, csr_epc;
  logic [reg_w-1:0] rd, ret_rd;
  logic [data_w-1:0] src_a, src_b, ret_result;
  cause_e dispatch_cause, csr_cause;
  logic full, ret_valid, ret_store, ret_branch, ret_bp_taken, flush, csr_valid;
  logic [rob_tag_w-1:0] robid;

  // case table
  logic [3:0] c_op [max_cases];
  logic [addr_w-1:0] c_addr [max_cases];
  logic c_dst [max_cases];
  logic [reg_w-1:0] c_rd [max_cases];
  logic [data_w-1:0] c_a [max_cases];
  logic [data_w-1:0] c_b [max_cases];
  logic c_bp [max_cases];
  logic [addr_w-1:0] c_target [max_cases];
  logic c_err [max_cases];
  logic [2:0] c_cause [max_cases];
  logic [data_w-1:0] c_exp [max_cases];
  int n_cases;
  bit loaded;

  int q[$];
  int errors;
  logic [31:0] lfsr_state;

  tb_clock clk_i (.clk(clk), .rst_n(rst_n));

  retire_core dut_i (.*);

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic int random_bits(int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // signed range check done in 64 bits
  function automatic bit alu_overflows(int c);
    longint sa, sb, r;
    sa = longint'($signed(c_a[c]));
    sb = longint'($signed(c_b[c]));
    if (c_op[c] == 4'd0) r = sa + sb;
    else if (c_op[c] == 4'd1) r = sa - sb;
    else return 1'b0;
    return (r > longint'(32'sh7fff_ffff)) || (r < longint'(32'sh8000_0000));
  endfunction

  function automatic bit is_alu_case(int c);
    return c_op[c] <= 4'd3;
  endfunction

  function automatic bit is_branch_case(int c);
    return c_op[c] >= 4'd4 && c_op[c] <= 4'd7;
  endfunction

  function automatic bit expects_error(int c);
    return c_err[c] || (is_alu_case(c) && alu_overflows(c));
  endfunction

  // retires without any visible output
  function automatic bit is_silent(int c);
    return !expects_error(c) && ((is_alu_case(c) && !c_dst[c]) || c_op[c] == 4'd9);
  endfunction

  function automatic bit has_visible();
    foreach (q[i]) begin
      if (!is_silent(q[i])) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic check_retire(int c);
    bit mis;
    logic [addr_w-1:0] pc;
    if (expects_error(c)) begin
      if (!csr_valid || !flush) report_mismatch($sformatf("case %0d no exception flush", c));
      if (csr_epc != c_addr[c]) report_mismatch($sformatf("case %0d epc %h", c, csr_epc));
      if (csr_cause != (c_err[c] ? cause_e'(c_cause[c]) : cause_overflow))
        report_mismatch($sformatf("case %0d cause %0d", c, csr_cause));
      if (flush_pc != trap_vec) report_mismatch($sformatf("case %0d flush_pc %h", c, flush_pc));
      if (ret_valid || ret_store || ret_branch)
        report_mismatch($sformatf("case %0d retired despite error", c));
      return;
    end
    if (csr_valid) report_mismatch($sformatf("case %0d unexpected csr_valid", c));
    if (is_branch_case(c)) begin
      mis = (c_op[c] == 4'd7) || (c_exp[c][0] != c_bp[c]);
      pc = c_exp[c][0] ? c_target[c] : c_addr[c] + 1'b1;
      if (!ret_branch) report_mismatch($sformatf("case %0d ret_branch low", c));
      if (ret_bp_taken != c_exp[c][0]) report_mismatch($sformatf("case %0d wrong outcome", c));
      if (flush != mis) report_mismatch($sformatf("case %0d flush %0b", c, flush));
      if (mis && flush_pc != pc) report_mismatch($sformatf("case %0d flush_pc %h", c, flush_pc));
    end else begin
      if (flush) report_mismatch($sformatf("case %0d unexpected flush", c));
      if (ret_branch) report_mismatch($sformatf("case %0d unexpected ret_branch", c));
    end
    if (ret_store != (c_op[c] == 4'd8)) report_mismatch($sformatf("case %0d ret_store", c));
    if (ret_valid != (is_alu_case(c) && c_dst[c]))
      report_mismatch($sformatf("case %0d ret_valid %0b", c, ret_valid));
    if (ret_valid && (ret_rd != c_rd[c] || ret_result != c_exp[c]))
      report_mismatch($sformatf("case %0d rd %0d result %h", c, ret_rd, ret_result));
  endtask

  // watchdog sized from the number of cases
  initial begin
    wait (loaded);
    #(n_cases * 40 * 100);
    $display("timeout: retirement did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    int fd, cnt, idx, gap, c, drops;
    logic [rob_tag_w-1:0] exp_tag;
    string line;
    dispatch_valid = 1'b0;
    op = op_nop;
    addr = '0;
    dst_en = 1'b0;
    rd = '0;
    src_a = '0;
    src_b = '0;
    bp_taken = 1'b0;
    target = '0;
    dispatch_error = 1'b0;
    dispatch_cause = cause_none;
    csr_tvec = trap_vec;
    errors = 0;
    n_cases = 0;
    lfsr_state = 32'h912c0763;
    fd = $fopen("testbench/retire_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file");
      $display("Errors found");
      $finish;
    end else begin
      while (!$feof(fd) && n_cases < max_cases) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#") continue;
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", c_op[n_cases],
                      c_addr[n_cases], c_dst[n_cases], c_rd[n_cases], c_a[n_cases],
                      c_b[n_cases], c_bp[n_cases], c_target[n_cases], c_err[n_cases],
                      c_cause[n_cases], c_exp[n_cases]);
        if (cnt == 11) n_cases++;
      end
      $fclose(fd);
      loaded = 1'b1;
      wait (rst_n);
      @(negedge clk);
      if (flush || csr_valid || ret_valid || ret_store || ret_branch || full || robid != '0)
        report_mismatch("outputs not idle after reset");
      idx = 0;
      gap = 0;
      drops = 0;
      exp_tag = '0;
      while (idx < n_cases || has_visible()) begin
        @(negedge clk);
        if (full && q.size() < rob_depth) report_mismatch("full with few entries outstanding");
        if (ret_valid || ret_store || ret_branch || csr_valid || flush) begin
          while (q.size() > 0 && is_silent(q[0])) void'(q.pop_front());
          if (q.size() == 0) begin
            report_mismatch("retirement with nothing outstanding");
          end else begin
            c = q.pop_front();
            check_retire(c);
            // fetch restarts right after the flushing case
            if (flush) idx = c + 1;
          end
          if (flush) begin
            q.delete();
            exp_tag = '0;
          end
        end
        dispatch_valid = 1'b0;
        if (gap > 0) begin
          gap--;
        end else if (idx < n_cases) begin
          dispatch_valid = 1'b1;
          op = op_e'(c_op[idx]);
          addr = c_addr[idx];
          dst_en = c_dst[idx];
          rd = c_rd[idx];
          src_a = c_a[idx];
          src_b = c_b[idx];
          bp_taken = c_bp[idx];
          target = c_target[idx];
          dispatch_error = c_err[idx];
          dispatch_cause = cause_e'(c_cause[idx]);
          if (full || flush) begin
            // dropped, driven again after one idle cycle
            if (full) drops++;
            gap = 1;
          end else begin
            if (robid != exp_tag) report_mismatch($sformatf("robid %0d", robid));
            q.push_back(idx);
            exp_tag++;
            idx++;
            gap = (idx >= burst_first && idx <= burst_last) ? 0 : random_bits(2);
          end
        end
      end
      @(negedge clk);
      dispatch_valid = 1'b0;
      repeat (4) @(negedge clk);
      $display("error count %0d, dispatches dropped while full %0d", errors, drops);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/tb_clock.sv ====
// clock generator with 100 ns period and the reset sequence
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int period_ns   = 100;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release lands on a falling edge
  initial begin
    rst_n = 1'b0;
    #(reset_cycles * period_ns);
    rst_n = 1'b1;
  end

endmodule
